//--- Bender.yml
package:
  name: write_dma

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/write_dma_pkg.sv
      - hdl/write_control_if.sv
      - hdl/showahead_fifo.sv
      - hdl/write_master.sv
      - hdl/control_csr.sv
      - hdl/write_dma_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/avalon_slave_model.sv
      - test/write_dma_tb.sv

//--- hdl/control_csr.sv
module control_csr (
	input  logic                     clk,
	input  logic                     reset,
	// host register port
	input  write_dma_pkg::csr_addr_t csr_address,
	input  logic                     csr_write,
	input  write_dma_pkg::data_t     csr_writedata,
	input  logic                     csr_read,
	output write_dma_pkg::data_t     csr_readdata,
	// command to the write master
	write_control_if.ctrl            ctl
);
	import write_dma_pkg::*;

	localparam int CTRL_GO_BIT     = 0;
	localparam int CTRL_FIXED_BIT  = 1;
	localparam int STATUS_DONE_BIT = 0;

	addr_t    base_reg;
	addr_t    length_reg;
	logic     fixed_reg;
	logic     go_reg;
	csr_reg_e reg_sel;      // offset seen as a register name
	logic     wr_control;
	data_t    control_word; // control as read back
	data_t    status_word;

	assign reg_sel    = csr_reg_e'(csr_address);
	assign wr_control = csr_write && (reg_sel == REG_CONTROL);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			base_reg   <= '0;
			length_reg <= '0;
			fixed_reg  <= 1'b0;
			go_reg     <= 1'b0;
		end
		else
		begin
			if (csr_write && (reg_sel == REG_BASE))
				base_reg <= csr_writedata;
			if (csr_write && (reg_sel == REG_LENGTH))
				length_reg <= csr_writedata; // expected a multiple of the word size
			if (wr_control)
				fixed_reg <= csr_writedata[CTRL_FIXED_BIT];
			// go only lives for the cycle after the host write
			go_reg <= wr_control && csr_writedata[CTRL_GO_BIT];
		end
	end

	// go is a strobe, so it never reads back
	always_comb
	begin
		control_word                 = '0;
		control_word[CTRL_FIXED_BIT] = fixed_reg;
	end

	always_comb
	begin
		status_word                  = '0;
		status_word[STATUS_DONE_BIT] = ctl.done; // live from the length counter
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			csr_readdata <= '0;
		end
		else if (csr_read)
		begin
			case (reg_sel)
				REG_BASE:    csr_readdata <= base_reg;
				REG_LENGTH:  csr_readdata <= length_reg;
				REG_CONTROL: csr_readdata <= control_word;
				REG_STATUS:  csr_readdata <= status_word;
				default:     csr_readdata <= '0;
			endcase
		end
	end

	assign ctl.write_base     = base_reg;
	assign ctl.write_length   = length_reg;
	assign ctl.fixed_location = fixed_reg;
	assign ctl.go             = go_reg;

endmodule

//--- hdl/showahead_fifo.sv
`include "write_dma_defs.svh"

module showahead_fifo #(
	parameter int WIDTH = `WD_DATA_WIDTH,
	parameter int DEPTH = `WD_FIFO_DEPTH
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 wr_en,
	input  write_dma_pkg::data_t wr_data,
	input  logic                 rd_en,
	output write_dma_pkg::data_t rd_data,
	output logic                 full,
	output logic                 empty
);

	localparam int DEPTH_LOG2 = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH]; // word storage
	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2-1:0] rd_ptr;
	logic [DEPTH_LOG2:0] count;    // one extra bit so it can reach DEPTH

	// pointer step that wraps after DEPTH - 1 for any depth
	function automatic logic [DEPTH_LOG2-1:0] next_ptr(input logic [DEPTH_LOG2-1:0] ptr);
		logic [DEPTH_LOG2-1:0] nxt;
		if (ptr == DEPTH_LOG2'(DEPTH - 1))
		begin
			nxt = '0;
		end
		else
		begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (wr_en)
				wr_ptr <= next_ptr(wr_ptr);
			if (rd_en)
				rd_ptr <= next_ptr(rd_ptr); // head moves on to the next word
			// occupancy follows the net of push and pop
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// head word is on the output while not empty
	assign rd_data = mem[rd_ptr];
	assign full    = (count == (DEPTH_LOG2 + 1)'(DEPTH));
	assign empty   = (count == '0);

endmodule

//--- hdl/write_control_if.sv
interface write_control_if;
	import write_dma_pkg::*;

	logic  fixed_location; // keep writing to the base address
	addr_t write_base;     // first byte address
	addr_t write_length;   // bytes to move
	logic  go;             // one-cycle load strobe
	logic  done;           // length counter is zero

	// register slave side
	modport ctrl
	(
		output fixed_location, write_base, write_length, go,
		input  done
	);

	// write master side
	modport master
	(
		input  fixed_location, write_base, write_length, go,
		output done
	);

endinterface

//--- hdl/write_dma_defs.svh
`ifndef WRITE_DMA_DEFS_SVH
`define WRITE_DMA_DEFS_SVH

// width of one data word on the user and memory sides
`define WD_DATA_WIDTH 32

// byte lanes per word, also the address and length step
`define WD_BYTE_WIDTH 4

// master address and byte length width
`define WD_ADDR_WIDTH 32

// user buffer sizing, depth kept a power of two
`define WD_FIFO_DEPTH_LOG2 5
`define WD_FIFO_DEPTH (1 << `WD_FIFO_DEPTH_LOG2)

// host register slave offset width
`define WD_CSR_ADDR_WIDTH 2

`endif

//--- hdl/write_dma_pkg.sv
`include "write_dma_defs.svh"

package write_dma_pkg;

	typedef logic [`WD_DATA_WIDTH-1:0] data_t;      // one user or memory word
	typedef logic [`WD_ADDR_WIDTH-1:0] addr_t;      // byte address or byte length
	typedef logic [`WD_BYTE_WIDTH-1:0] byteen_t;    // one bit per byte lane
	typedef logic [`WD_CSR_ADDR_WIDTH-1:0] csr_addr_t;

	// host register map, word offsets
	typedef enum csr_addr_t
	{
		REG_BASE    = 0,
		REG_LENGTH  = 1,
		REG_CONTROL = 2, // bit 0 go, bit 1 fixed_location
		REG_STATUS  = 3  // bit 0 done
	} csr_reg_e;

endpackage

//--- hdl/write_dma_top.sv
module write_dma_top (
	input  logic                     clk,
	input  logic                     reset,
	// host register port
	input  write_dma_pkg::csr_addr_t csr_address,
	input  logic                     csr_write,
	input  write_dma_pkg::data_t     csr_writedata,
	input  logic                     csr_read,
	output write_dma_pkg::data_t     csr_readdata,
	// user data port
	input  logic                     user_write_buffer,
	input  write_dma_pkg::data_t     user_buffer_data,
	output logic                     user_buffer_full,
	// memory write port
	output write_dma_pkg::addr_t     master_address,
	output logic                     master_write,
	output write_dma_pkg::byteen_t   master_byteenable,
	output write_dma_pkg::data_t     master_writedata,
	input  logic                     master_waitrequest
);

	// command and done between the register slave and the master
	write_control_if ctl_if ();

	control_csr csr0 (
		.clk           (clk),
		.reset         (reset),
		.csr_address   (csr_address),
		.csr_write     (csr_write),
		.csr_writedata (csr_writedata),
		.csr_read      (csr_read),
		.csr_readdata  (csr_readdata),
		.ctl           (ctl_if.ctrl)
	);

	write_master master0 (
		.clk                (clk),
		.reset              (reset),
		.ctl                (ctl_if.master),
		.user_write_buffer  (user_write_buffer),
		.user_buffer_data   (user_buffer_data),
		.user_buffer_full   (user_buffer_full),
		.master_address     (master_address),
		.master_write       (master_write),
		.master_byteenable  (master_byteenable),
		.master_writedata   (master_writedata),
		.master_waitrequest (master_waitrequest)
	);

endmodule

//--- hdl/write_master.sv
`include "write_dma_defs.svh"

module write_master (
	input  logic                     clk,
	input  logic                     reset,
	// transfer command and status
	write_control_if.master          ctl,
	// user data feed
	input  logic                     user_write_buffer,
	input  write_dma_pkg::data_t     user_buffer_data,
	output logic                     user_buffer_full,
	// memory-mapped write port
	output write_dma_pkg::addr_t     master_address,
	output logic                     master_write,
	output write_dma_pkg::byteen_t   master_byteenable,
	output write_dma_pkg::data_t     master_writedata,
	input  logic                     master_waitrequest
);
	import write_dma_pkg::*;

	logic  fixed_location_q; // latched on go
	addr_t address;          // steps one word per accepted write
	addr_t length;           // bytes still to move
	logic  done;
	logic  buffer_empty;
	logic  accept;           // word leaves on this edge

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			fixed_location_q <= 1'b0;
		end
		else if (ctl.go)
		begin
			fixed_location_q <= ctl.fixed_location;
		end
	end

	// address counter
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			address <= '0;
		end
		else if (ctl.go)
		begin
			address <= ctl.write_base;
		end
		else if (accept && !fixed_location_q)
		begin
			address <= address + addr_t'(`WD_BYTE_WIDTH); // full words only
		end
	end

	// length counter
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			length <= '0; // comes out of reset done
		end
		else if (ctl.go)
		begin
			length <= ctl.write_length;
		end
		else if (accept)
		begin
			length <= length - addr_t'(`WD_BYTE_WIDTH);
		end
	end

	assign done     = (length == '0);
	assign ctl.done = done;

	assign master_write = !buffer_empty && !done;
	assign accept       = !buffer_empty && !master_waitrequest && !done;

	assign master_address    = address;
	assign master_byteenable = '1; // every access is a whole word

	// user words wait here until the bus takes them
	showahead_fifo #(
		.WIDTH (`WD_DATA_WIDTH),
		.DEPTH (`WD_FIFO_DEPTH)
	) user_fifo (
		.clk     (clk),
		.reset   (reset),
		.wr_en   (user_write_buffer),
		.wr_data (user_buffer_data),
		.rd_en   (accept),
		.rd_data (master_writedata),
		.full    (user_buffer_full),
		.empty   (buffer_empty)
	);

endmodule

//--- test/avalon_slave_model.sv
module avalon_slave_model #(
	parameter int LOG_SIZE = 1024
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [7:0]             wait_percent, // chance of waitrequest per cycle
	input  write_dma_pkg::addr_t   address,
	input  logic                   write,
	input  write_dma_pkg::byteen_t byteenable,
	input  write_dma_pkg::data_t   writedata,
	output logic                   waitrequest
);
	import write_dma_pkg::*;

	integer      seed = 32'hbf62_af64;
	logic [31:0] roll;

	// accepted writes in arrival order
	addr_t   log_addr [LOG_SIZE];
	data_t   log_data [LOG_SIZE];
	byteen_t log_be [LOG_SIZE];
	int      log_count = 0;

	// new back-pressure value on each falling edge
	always @(negedge clk or posedge reset)
	begin
		if (reset)
		begin
			waitrequest <= 1'b0;
		end
		else
		begin
			roll = $random(seed);
			waitrequest <= ((roll % 100) < wait_percent);
		end
	end

	// a word is taken on a rising edge with waitrequest low
	always @(posedge clk)
	begin
		if (!reset && write && !waitrequest)
		begin
			if (log_count < LOG_SIZE)
			begin
				log_addr[log_count] = address;
				log_data[log_count] = writedata;
				log_be[log_count]   = byteenable;
			end
			log_count = log_count + 1;
		end
	end

endmodule

//--- test/write_dma_tb.sv
`include "write_dma_defs.svh"

module write_dma_tb;
	import write_dma_pkg::*;

	localparam int NUM_ENTRIES = 6;
	localparam int WORD_BYTES  = `WD_BYTE_WIDTH;

	typedef struct packed
	{
		addr_t      base;
		addr_t      length;   // bytes
		logic       fixed;
		logic [7:0] wait_pct;
		logic [7:0] preload;  // words pushed before go
		data_t      seed;     // data of the first word
	} stim_t;

	logic      clk = 1'b0;
	logic      reset;
	csr_addr_t csr_address;
	logic      csr_write;
	data_t     csr_writedata;
	logic      csr_read;
	data_t     csr_readdata;
	logic      user_write_buffer;
	data_t     user_buffer_data;
	logic      user_buffer_full;
	addr_t     master_address;
	logic      master_write;
	byteen_t   master_byteenable;
	data_t     master_writedata;
	logic      master_waitrequest;
	logic [7:0] wait_percent;
	stim_t     stim [NUM_ENTRIES];
	logic      table_ready = 1'b0;

	always #5 clk = ~clk;

	write_dma_top dut0 (
		.clk                (clk),
		.reset              (reset),
		.csr_address        (csr_address),
		.csr_write          (csr_write),
		.csr_writedata      (csr_writedata),
		.csr_read           (csr_read),
		.csr_readdata       (csr_readdata),
		.user_write_buffer  (user_write_buffer),
		.user_buffer_data   (user_buffer_data),
		.user_buffer_full   (user_buffer_full),
		.master_address     (master_address),
		.master_write       (master_write),
		.master_byteenable  (master_byteenable),
		.master_writedata   (master_writedata),
		.master_waitrequest (master_waitrequest)
	);

	avalon_slave_model slave0 (
		.clk          (clk),
		.reset        (reset),
		.wait_percent (wait_percent),
		.address      (master_address),
		.write        (master_write),
		.byteenable   (master_byteenable),
		.writedata    (master_writedata),
		.waitrequest  (master_waitrequest)
	);

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_status(input string name, input data_t got, input data_t exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_byteen(input string name, input byteen_t got, input byteen_t exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	// host access entered and left on a falling edge
	task automatic write_reg(input csr_addr_t offset, input data_t value);
		csr_address   = offset;
		csr_writedata = value;
		csr_write     = 1'b1;
		@(negedge clk);
		csr_write = 1'b0;
	endtask

	task automatic read_reg(input csr_addr_t offset, output data_t value);
		csr_address = offset;
		csr_read    = 1'b1;
		@(negedge clk);
		csr_read = 1'b0;
		value    = csr_readdata; // registered on the edge just passed
	endtask

	task automatic push_word(input data_t value);
		while (user_buffer_full)
			@(negedge clk);
		user_buffer_data  = value;
		user_write_buffer = 1'b1;
		@(negedge clk);
		user_write_buffer = 1'b0;
	endtask

	task automatic run_entry(input int idx);
		stim_t s;
		int    words;
		int    first;
		int    k;
		data_t rd;
		addr_t exp_addr;
		s            = stim[idx];
		words        = s.length / WORD_BYTES;
		first        = slave0.log_count;
		wait_percent = s.wait_pct;
		for (k = 0; k < s.preload; k++)
			push_word(s.seed + k);
		// length is still zero, so the buffer only fills
		check_flag("master_write", master_write, 1'b0);
		check_count("accepted words before go", slave0.log_count - first, 0);
		if (s.preload == `WD_FIFO_DEPTH)
			check_flag("user_buffer_full", user_buffer_full, 1'b1);
		write_reg(REG_BASE, s.base);
		write_reg(REG_LENGTH, s.length);
		write_reg(REG_CONTROL, {30'b0, s.fixed, 1'b1});
		@(negedge clk); // counters load on the go edge
		for (k = s.preload; k < words; k++)
			push_word(s.seed + k);
		rd = '0;
		while (!rd[0])
			read_reg(REG_STATUS, rd);
		check_count("accepted words at done", slave0.log_count - first, words);
		check_flag("user_buffer_full", user_buffer_full, 1'b0);
		for (k = 0; k < words; k++)
		begin
			exp_addr = s.fixed ? s.base : s.base + addr_t'(WORD_BYTES * k);
			check_addr("master_address", slave0.log_addr[first + k], exp_addr);
			check_data("master_writedata", slave0.log_data[first + k], s.seed + k);
			check_byteen("master_byteenable", slave0.log_be[first + k], '1);
		end
	endtask

	initial
	begin
		data_t rd;
		int    i;
		reset              = 1'b1;
		csr_address        = '0;
		csr_write          = 1'b0;
		csr_writedata      = '0;
		csr_read           = 1'b0;
		user_write_buffer  = 1'b0;
		user_buffer_data   = '0;
		wait_percent       = '0;
		// base, length, fixed, waitrequest percent, preload, data seed
		stim[0] = '{32'h0000_1000, 32'd64, 1'b0, 8'd0, 8'd16, 32'h1000_0000};
		stim[1] = '{32'h0000_2040, 32'd40, 1'b1, 8'd0, 8'd4, 32'h2000_0100};
		stim[2] = '{32'h0001_0000, 32'd96, 1'b0, 8'd50, 8'd8, 32'h3000_0000};
		stim[3] = '{32'h0002_0000, 32'd80, 1'b0, 8'd90, 8'd0, 32'h4000_0000};
		stim[4] = '{32'h0003_0000, 32'd128, 1'b0, 8'd0, 8'd32, 32'h5000_0000}; // fills the buffer
		stim[5] = '{32'h0004_0100, 32'd48, 1'b1, 8'd50, 8'd12, 32'h6000_0000};
		table_ready = 1'b1;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		check_flag("master_write", master_write, 1'b0);
		check_flag("user_buffer_full", user_buffer_full, 1'b0);
		check_data("csr_readdata", csr_readdata, '0);
		read_reg(REG_STATUS, rd);
		check_status("status", rd, 32'h1);
		read_reg(REG_BASE, rd);
		check_addr("base", rd, '0);
		read_reg(REG_LENGTH, rd);
		check_addr("length", rd, '0);
		write_reg(REG_BASE, 32'hdead_beec);
		write_reg(REG_LENGTH, 32'h0000_0ff0);
		read_reg(REG_BASE, rd);
		check_addr("base", rd, 32'hdead_beec);
		read_reg(REG_LENGTH, rd);
		check_addr("length", rd, 32'h0000_0ff0);
		write_reg(REG_LENGTH, '0);
		write_reg(REG_CONTROL, 32'h3); // go with zero length leaves the master idle
		read_reg(REG_CONTROL, rd);
		check_data("control", rd, 32'h2);
		read_reg(REG_STATUS, rd);
		check_status("status", rd, 32'h1);
		write_reg(REG_CONTROL, '0);
		for (i = 0; i < NUM_ENTRIES; i++)
			run_entry(i);
		$display("Verification passed");
		$finish;
	end

	// watchdog scaled by the number of words in the table
	initial
	begin
		int total;
		int i;
		total = 0;
		wait (table_ready);
		for (i = 0; i < NUM_ENTRIES; i++)
			total = total + stim[i].length / WORD_BYTES;
		repeat (total * 40 + 2000) @(posedge clk);
		report_failure("timeout: the transfers did not finish within the watchdog limit");
	end

endmodule

//--- verilog.f
+incdir+hdl
hdl/write_dma_pkg.sv
hdl/write_control_if.sv
hdl/showahead_fifo.sv
hdl/write_master.sv
hdl/control_csr.sv
hdl/write_dma_top.sv
test/avalon_slave_model.sv
test/write_dma_tb.sv
